// ==== design/cam_spi_pkg.sv ====
`default_nettype none

package cam_spi_pkg;

    localparam int pix_w  = 8;  // camera bus width
    localparam int addr_w = 6;  // pixel address inside a line, up to 64 pixels

    typedef logic [pix_w-1:0] pix_t;
    typedef logic [addr_w:0]  len_t;  // one extra bit so a full line fits

    // frame/line tracking on the synchronized camera syncs
    typedef enum logic [1:0] {
        cap_fot = 2'd0,  // outside a frame
        cap_rot = 2'd1,  // in a frame, between lines
        cap_wr  = 2'd2   // inside a line, pixels land in a buffer
    } cap_state_e;

    typedef enum logic [1:0] {
        snd_idle  = 2'd0,  // wait for the next buffer in turn
        snd_shift = 2'd1,  // cs low, one bit per sck
        snd_gap   = 2'd2   // cs high hold between lines
    } snd_state_e;

    // pixel write, broadcast to every buffer
    typedef struct packed {
        logic [2:0]        buf_idx;
        logic [addr_w-1:0] addr;
        pix_t              data;
        logic              we;
    } line_wr_t;

    // end of a stored line, carries its final length
    typedef struct packed {
        logic       close;
        logic [2:0] buf_idx;
        len_t       len;
    } line_close_t;

    // sender done with a buffer
    typedef struct packed {
        logic       rel;
        logic [2:0] buf_idx;
    } line_rel_t;

    // what each buffer shows the sender
    typedef struct packed {
        logic ready;
        len_t len;
        pix_t data;
    } line_rd_t;

endpackage

`default_nettype wire

// ==== design/pixel_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_capture #(
    parameter int num_buf  = 2,
    parameter int line_max = 16
) (
    input  logic                     sck,
    input  logic                     sys_rst_n,
    input  logic                     cam_pclk,
    input  logic                     cam_frame_valid,
    input  logic                     cam_line_valid,
    input  cam_spi_pkg::pix_t        cam_data,
    input  logic                     credit_ret,
    output cam_spi_pkg::line_wr_t    wr,
    output cam_spi_pkg::line_close_t close,
    output logic [7:0]               drop_cnt
);
    import cam_spi_pkg::*;

    localparam int pw = (num_buf > 1) ? $clog2(num_buf) : 1;

    logic [1:0]    pclk_sync;  // two-flop synchronizers
    logic          pclk_d;     // edge detect
    logic [1:0]    fv_sync;
    logic [1:0]    lv_sync;
    pix_t          data_s1;
    pix_t          data_s2;
    cap_state_e    state;
    cap_state_e    state_nxt;
    logic          line_ok;    // this line holds a credit
    len_t          pix_cnt;
    len_t          line_len;
    logic [pw-1:0] wr_ptr;     // round-robin buffer choice
    logic [3:0]    credit_cnt;
    logic          fv;
    logic          lv;
    logic          pclk_rise;
    logic          take_pix;
    logic          line_start;
    logic          line_end;
    logic          credit_take;
    logic          zero_ret;
    logic          do_close;

    always_ff @(posedge sck or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pclk_sync <= '0;
            pclk_d    <= 1'b0;
            fv_sync   <= '0;
            lv_sync   <= '0;
            data_s1   <= '0;
            data_s2   <= '0;
        end else begin
            pclk_sync <= {pclk_sync[0], cam_pclk};
            pclk_d    <= pclk_sync[1];
            fv_sync   <= {fv_sync[0], cam_frame_valid};
            lv_sync   <= {lv_sync[0], cam_line_valid};
            data_s1   <= cam_data;  // camera holds data around the edge
            data_s2   <= data_s1;
        end
    end

    assign fv        = fv_sync[1];
    assign lv        = lv_sync[1];
    assign pclk_rise = pclk_sync[1] & ~pclk_d;

    always_comb begin
        state_nxt = state;
        case (state)
            cap_fot: if (fv && lv) state_nxt = cap_wr;
                     else if (fv)  state_nxt = cap_rot;
            cap_rot: if (lv)       state_nxt = cap_wr;   // line valid wins
                     else if (!fv) state_nxt = cap_fot;
            cap_wr:  if (!lv)      state_nxt = cap_rot;
                     else if (!fv) state_nxt = cap_fot;
            default: state_nxt = cap_fot;
        endcase
    end

    assign line_start  = (state != cap_wr) && (state_nxt == cap_wr);
    assign line_end    = (state == cap_wr) && (state_nxt != cap_wr);
    assign take_pix    = (state == cap_wr) && pclk_rise && line_ok &&
                         (pix_cnt < len_t'(line_max));  // extra pixels fall off
    assign line_len    = pix_cnt + len_t'(take_pix);   // count incl. a last-cycle pixel
    assign credit_take = line_start && (credit_cnt != 4'd0);
    assign do_close    = line_end && line_ok && (line_len != '0);
    assign zero_ret    = line_end && line_ok && (line_len == '0);  // empty line keeps nothing

    always_ff @(posedge sck or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= cap_fot;
            line_ok    <= 1'b0;
            pix_cnt    <= '0;
            wr_ptr     <= '0;
            credit_cnt <= 4'(num_buf);  // every buffer free
            drop_cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (line_start) begin
                line_ok <= (credit_cnt != 4'd0);
                pix_cnt <= '0;
            end else if (take_pix) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            if (do_close)
                wr_ptr <= (wr_ptr == pw'(num_buf - 1)) ? '0 : wr_ptr + 1'b1;
            credit_cnt <= credit_cnt + 4'(credit_ret) + 4'(zero_ret) - 4'(credit_take);
            if (line_start && (credit_cnt == 4'd0) && (drop_cnt != 8'hff))
                drop_cnt <= drop_cnt + 1'b1;  // saturating
        end
    end

    // write and close go out one cycle late
    always_ff @(posedge sck or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr    <= '0;
            close <= '0;
        end else begin
            wr.we         <= take_pix;
            wr.buf_idx    <= 3'(wr_ptr);
            wr.addr       <= pix_cnt[addr_w-1:0];
            wr.data       <= data_s2;
            close.close   <= do_close;
            close.buf_idx <= 3'(wr_ptr);
            close.len     <= line_len;
        end
    end

endmodule

`default_nettype wire

// ==== design/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
    parameter int idx      = 0,
    parameter int line_max = 16
) (
    input  logic                         sck,
    input  logic                         sys_rst_n,
    input  cam_spi_pkg::line_wr_t        wr,
    input  cam_spi_pkg::line_close_t     close,
    input  logic [cam_spi_pkg::addr_w-1:0] rd_addr,
    input  cam_spi_pkg::line_rel_t       release_buf,
    output cam_spi_pkg::line_rd_t        rd
);
    import cam_spi_pkg::*;

    localparam int aw = (line_max > 1) ? $clog2(line_max) : 1;

    pix_t mem [line_max];  // one line of pixels
    logic ready;           // full line waiting for the sender
    len_t len;
    logic wr_hit;
    logic close_hit;
    logic rel_hit;

    // only traffic for this buffer counts
    assign wr_hit    = wr.we && (wr.buf_idx == 3'(idx));
    assign close_hit = close.close && (close.buf_idx == 3'(idx));
    assign rel_hit   = release_buf.rel && (release_buf.buf_idx == 3'(idx));

    always_ff @(posedge sck) begin
        if (wr_hit)
            mem[wr.addr[aw-1:0]] <= wr.data;
    end

    always_ff @(posedge sck or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ready <= 1'b0;
            len   <= '0;
        end else begin
            if (rel_hit)
                ready <= 1'b0;  // sender is done, credit already back
            if (close_hit) begin
                ready <= 1'b1;
                len   <= close.len;
            end
        end
    end

    // read path has no register, sender picks the address
    assign rd = '{ready: ready, len: len, data: mem[rd_addr[aw-1:0]]};

endmodule

`default_nettype wire

// ==== design/spi_line_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_line_sender #(
    parameter int num_buf = 2
) (
    input  logic                           sck,
    input  logic                           sys_rst_n,
    input  cam_spi_pkg::line_rd_t          rd_lines [num_buf],
    output logic [cam_spi_pkg::addr_w-1:0] rd_addr,
    output cam_spi_pkg::line_rel_t         release_buf,
    output logic                           credit_ret,
    output logic                           miso,
    output logic                           cs_n_line
);
    import cam_spi_pkg::*;

    localparam int pw = (num_buf > 1) ? $clog2(num_buf) : 1;

    snd_state_e    state;
    logic [pw-1:0] snd_ptr;   // buffer whose turn it is
    len_t          pix_idx;   // pixel being shifted
    logic [2:0]    bit_idx;   // msb first
    logic          gap_cnt;
    line_rd_t      cur;
    logic          last_bit;

    assign cur      = rd_lines[snd_ptr];
    assign rd_addr  = pix_idx[addr_w-1:0];
    assign last_bit = (bit_idx == 3'd0) && ((pix_idx + 1'b1) == cur.len);

    always_ff @(posedge sck or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= snd_idle;
            snd_ptr     <= '0;
            pix_idx     <= '0;
            bit_idx     <= 3'd7;
            gap_cnt     <= 1'b0;
            miso        <= 1'b0;
            cs_n_line   <= 1'b1;
            credit_ret  <= 1'b0;
            release_buf <= '0;
        end else begin
            credit_ret  <= 1'b0;  // single-cycle pulses
            release_buf <= '0;
            case (state)
                snd_idle: begin
                    if (cur.ready)
                        state <= snd_shift;  // lines go out strictly in order
                end
                snd_shift: begin
                    cs_n_line <= 1'b0;
                    miso      <= cur.data[bit_idx];
                    bit_idx   <= bit_idx - 3'd1;  // wraps 0 -> 7
                    if (bit_idx == 3'd0)
                        pix_idx <= pix_idx + 1'b1;
                    if (last_bit) begin
                        state   <= snd_gap;
                        gap_cnt <= 1'b0;
                    end
                end
                snd_gap: begin
                    if (!gap_cnt) begin
                        // cs rises together with the credit
                        cs_n_line   <= 1'b1;
                        miso        <= 1'b0;
                        credit_ret  <= 1'b1;
                        release_buf <= '{rel: 1'b1, buf_idx: 3'(snd_ptr)};
                        snd_ptr     <= (snd_ptr == pw'(num_buf - 1)) ? '0 : snd_ptr + 1'b1;
                        pix_idx     <= '0;
                        bit_idx     <= 3'd7;
                        gap_cnt     <= 1'b1;
                    end else begin
                        state <= snd_idle;  // idle adds one more high cycle
                    end
                end
                default: state <= snd_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/cam_spi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_spi_top #(
    parameter int num_buf  = 2,   // 2..8 line buffers
    parameter int line_max = 16   // pixels kept per line, 64 at most
) (
    input  logic              sck,
    input  logic              sys_rst_n,
    input  logic              cam_pclk,         // async to sck
    input  logic              cam_frame_valid,
    input  logic              cam_line_valid,
    input  cam_spi_pkg::pix_t cam_data,
    output logic              miso,
    output logic              cs_n_line,        // one low window per line
    output logic [7:0]        drop_cnt          // lines lost for lack of a buffer
);
    import cam_spi_pkg::*;

    line_wr_t          wr;           // pixel writes, all buffers see them
    line_close_t       close;        // line end with length
    line_rel_t         release_buf;  // sender frees a buffer
    logic              credit_ret;
    logic [addr_w-1:0] rd_addr;      // shared read address
    line_rd_t          rd_lines [num_buf];

    pixel_capture #(
        .num_buf  (num_buf),
        .line_max (line_max)
    ) u_pixel_capture (
        .sck             (sck),
        .sys_rst_n       (sys_rst_n),
        .cam_pclk        (cam_pclk),
        .cam_frame_valid (cam_frame_valid),
        .cam_line_valid  (cam_line_valid),
        .cam_data        (cam_data),
        .credit_ret      (credit_ret),
        .wr              (wr),
        .close           (close),
        .drop_cnt        (drop_cnt)
    );

    // buffer index comes in as a parameter
    for (genvar i = 0; i < num_buf; i++) begin : g_buf
        line_buffer #(
            .idx      (i),
            .line_max (line_max)
        ) u_line_buffer (
            .sck         (sck),
            .sys_rst_n   (sys_rst_n),
            .wr          (wr),
            .close       (close),
            .rd_addr     (rd_addr),
            .release_buf (release_buf),
            .rd          (rd_lines[i])
        );
    end

    spi_line_sender #(
        .num_buf (num_buf)
    ) u_spi_line_sender (
        .sck         (sck),
        .sys_rst_n   (sys_rst_n),
        .rd_lines    (rd_lines),
        .rd_addr     (rd_addr),
        .release_buf (release_buf),
        .credit_ret  (credit_ret),
        .miso        (miso),
        .cs_n_line   (cs_n_line)
    );

endmodule

`default_nettype wire

// ==== sim/tb_cam_spi_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cam_spi_props (
    input logic sck,
    input logic sys_rst_n,
    input logic cs_n_line,
    input logic miso,
    input logic credit_ret
);

    int assert_fails = 0;  // failed assertions so far

    // chip select stays up at least 2 cycles between windows
    cs_gap_min: assert property (@(posedge sck) disable iff (!sys_rst_n)
        $rose(cs_n_line) |=> cs_n_line)
    else begin
        $error("cs_n_line high gap shorter than 2 cycles");
        assert_fails++;
    end

    credit_on_rise: assert property (@(posedge sck) disable iff (!sys_rst_n)
        credit_ret |-> $rose(cs_n_line))  // credit only as a window closes
    else begin
        $error("credit_ret outside a cs_n_line rise");
        assert_fails++;
    end

    miso_quiet: assert property (@(posedge sck) disable iff (!sys_rst_n)
        cs_n_line |-> !miso)
    else begin
        $error("miso high while cs_n_line is high");
        assert_fails++;
    end

endmodule

bind spi_line_sender tb_cam_spi_props u_props (
    .sck        (sck),
    .sys_rst_n  (sys_rst_n),
    .cs_n_line  (cs_n_line),
    .miso       (miso),
    .credit_ret (credit_ret)
);

`default_nettype wire

// ==== sim/tb_cam_spi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cam_spi;
    import cam_spi_pkg::*;

    localparam int num_buf  = 2;
    localparam int line_max = 16;

    logic       sck = 1'b0;
    logic       sys_rst_n;
    logic       cam_pclk;
    logic       cam_frame_valid;
    logic       cam_line_valid;
    pix_t       cam_data;
    logic       miso;
    logic       cs_n_line;
    logic [7:0] drop_cnt;

    integer seed = 32'hd67c;
    pix_t   line_pix [64];     // pixels of the line being driven
    pix_t   exp_bytes [$];     // expected pixels, all pending lines back to back
    int     exp_lens [$];      // expected window length per line, in pixels
    int     exp_drops = 0;
    int     err_cnt = 0;
    int     timeout_cnt = 0;
    int     windows_seen = 0;
    logic   in_win = 1'b0;     // monitor inside a cs window
    int     bit_cnt = 0;
    pix_t   cur_byte = '0;
    pix_t   got_bytes [$];

    cam_spi_top #(
        .num_buf  (num_buf),
        .line_max (line_max)
    ) cam_spi_top_i (
        .sck             (sck),
        .sys_rst_n       (sys_rst_n),
        .cam_pclk        (cam_pclk),
        .cam_frame_valid (cam_frame_valid),
        .cam_line_valid  (cam_line_valid),
        .cam_data        (cam_data),
        .miso            (miso),
        .cs_n_line       (cs_n_line),
        .drop_cnt        (drop_cnt)
    );

    always #20 sck = ~sck;  // 40 ns period

    // truncation and drop rule, gives the pixel count that should come out
    function automatic int expect_line(input int n_pix, input bit buf_free);
        if (!buf_free)
            return 0;  // no credit, whole line lost
        if (n_pix > line_max)
            return line_max;
        return n_pix;
    endfunction

    task automatic fill_pixels(input int n);
        int i;
        for (i = 0; i < n; i++)
            line_pix[i] = pix_t'($random(seed));
    endtask

    // lv up, 2 lead cycles, then pclk high 4 / low 4 per pixel
    task automatic drive_line(input int n, input bit lv_on);
        int i;
        @(negedge sck);
        cam_line_valid = lv_on;
        cam_pclk       = 1'b0;
        cam_data       = line_pix[0];
        repeat (2) @(negedge sck);
        for (i = 0; i < n; i++) begin
            cam_pclk = 1'b1;  // rising edge samples this pixel
            if (i == n - 1) begin
                @(negedge sck);  // line ends right after the last edge
            end else begin
                repeat (4) @(negedge sck);
                cam_pclk = 1'b0;
                cam_data = line_pix[i+1];
                repeat (4) @(negedge sck);
            end
        end
        if (n == 0)
            repeat (6) @(negedge sck);  // empty line
        cam_line_valid = 1'b0;
        cam_pclk       = 1'b0;
    endtask

    task automatic send_line(input int n, input bit buf_free);
        int i;
        int keep;
        fill_pixels(n);
        keep = expect_line(n, buf_free);
        for (i = 0; i < keep; i++)
            exp_bytes.push_back(line_pix[i]);
        if (keep > 0)
            exp_lens.push_back(keep);
        if (!buf_free)
            exp_drops++;
        drive_line(n, 1'b1);
    endtask

    task automatic frame_set(input logic fv);
        @(negedge sck);
        cam_frame_valid = fv;
        repeat (4) @(negedge sck);
    endtask

    // all pending lines out and cs back up
    task automatic wait_drain(input int limit);
        int cyc;
        cyc = 0;
        while ((exp_lens.size() != 0 || in_win) && cyc < limit) begin
            @(negedge sck);
            cyc++;
        end
        if (exp_lens.size() != 0 || in_win) begin
            $display("timeout after %0d cycles, %0d lines still not sent on miso",
                     cyc, exp_lens.size());
            timeout_cnt++;
        end
        repeat (8) @(negedge sck);  // credit back, gap over
    endtask

    task automatic check_window();
        int   exp_len;
        int   i;
        pix_t exp_pix;
        if (exp_lens.size() == 0) begin
            $display("unexpected cs_n_line window of %0d bits with no line pending", bit_cnt);
            err_cnt++;
            return;
        end
        exp_len = exp_lens.pop_front();
        windows_seen++;
        if (bit_cnt != 8 * exp_len) begin
            $display("FAILED cs_n_line window bits: got 0x%0h expected 0x%0h",
                     bit_cnt, 8 * exp_len);
            err_cnt++;
        end
        for (i = 0; i < exp_len; i++) begin
            exp_pix = exp_bytes.pop_front();
            if (i < got_bytes.size()) begin
                if (got_bytes[i] != exp_pix) begin
                    $display("FAILED miso pixel %0d: got 0x%02h expected 0x%02h",
                             i, got_bytes[i], exp_pix);
                    err_cnt++;
                end
            end
        end
    endtask

    // mid-cycle sampling, each bit seen once while cs is low
    always @(negedge sck) begin
        if (!sys_rst_n) begin
            in_win  = 1'b0;
            bit_cnt = 0;
        end else if (!cs_n_line) begin
            if (!in_win) begin
                in_win  = 1'b1;
                bit_cnt = 0;
                got_bytes.delete();
            end
            cur_byte = {cur_byte[6:0], miso};  // msb first
            bit_cnt++;
            if (bit_cnt % 8 == 0)
                got_bytes.push_back(cur_byte);
        end else if (in_win) begin
            in_win = 1'b0;  // cs rise closes the window
            check_window();
        end
    end

    initial begin : main
        int lens [6];
        int k;
        lens            = '{1, 7, 16, 3, 0, 12};
        sys_rst_n       = 1'b0;
        cam_pclk        = 1'b0;
        cam_frame_valid = 1'b0;
        cam_line_valid  = 1'b0;
        cam_data        = '0;
        repeat (5) @(negedge sck);
        sys_rst_n = 1'b1;
        repeat (3) @(negedge sck);

        // idle outputs after reset
        if (cs_n_line !== 1'b1) begin
            $display("FAILED cs_n_line after reset: got 0x%0h expected 0x1", cs_n_line);
            err_cnt++;
        end
        if (miso !== 1'b0) begin
            $display("FAILED miso after reset: got 0x%0h expected 0x0", miso);
            err_cnt++;
        end
        if (drop_cnt !== 8'h00) begin
            $display("FAILED drop_cnt after reset: got 0x%02h expected 0x00", drop_cnt);
            err_cnt++;
        end

        frame_set(1'b1);
        send_line(5, 1'b1);  // single short line
        wait_drain(1000);

        for (k = 0; k < 6; k++) begin
            send_line(lens[k], 1'b1);  // long idle after each, all buffers free
            wait_drain(2000);
        end
        frame_set(1'b0);

        // stray pixels, no frame then no line
        fill_pixels(6);
        drive_line(6, 1'b1);
        frame_set(1'b1);
        fill_pixels(6);
        drive_line(6, 1'b0);
        repeat (150) @(negedge sck);

        send_line(20, 1'b1);  // truncated to line_max
        wait_drain(3000);

        // back to back, third line finds no credit
        send_line(16, 1'b1);
        @(negedge sck);
        send_line(16, 1'b1);
        @(negedge sck);
        send_line(16, 1'b0);
        wait_drain(4000);
        if (drop_cnt !== 8'(exp_drops)) begin
            $display("FAILED drop_cnt: got 0x%02h expected 0x%02h", drop_cnt, 8'(exp_drops));
            err_cnt++;
        end
        frame_set(1'b0);
        repeat (100) @(negedge sck);

        if (exp_bytes.size() != 0) begin
            $display("%0d expected pixels never appeared on miso", exp_bytes.size());
            err_cnt++;
        end
        if (in_win) begin
            $display("cs_n_line still low at end of run, window of %0d bits not checked",
                     bit_cnt);
            err_cnt++;
        end
        err_cnt += cam_spi_top_i.u_spi_line_sender.u_props.assert_fails;
        $display("windows checked: %0d, errors: %0d, timeouts: %0d",
                 windows_seen, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cam_spi.f ====
design/cam_spi_pkg.sv
design/pixel_capture.sv
design/line_buffer.sv
design/spi_line_sender.sv
design/cam_spi_top.sv
sim/tb_cam_spi_props.sv
sim/tb_cam_spi.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the camera-to-SPI bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cam_spi -f cam_spi.f -o tb_cam_spi
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cam_spi +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
